// File: verification/dequant_patterns.hex
// id scale acc0 acc1 acc2 acc3 res0 res1 res2 res3 ovf_mask
// acc and res in lane order 0..3, mask bit n for lane n
// no scale written yet
00000010 00000000 00000005 FFFFFFF9 00000000 00000064
00000000 80000000 00000000 00000000 00000000
00000011 00000000 FFFFFFFF 7FFFFFFF 80000000 0000002A
80000000 00000000 80000000 00000000 00000000
// normal scales 1.0 and 1.5
00000020 3F800000 00000001 FFFFFFFF 00000000 00000003
38820500 B8820500 00000000 39430780 00000000
00000021 3F800000 00000400 FFFF0000 7FFFFFFF 80000000
3D820500 C0820500 48020500 C8020500 00000000
00000022 3FC00000 00000001 FFFFFFFE 00000003 00000400
38C30780 B9430780 399245A0 3DC30780 00000000
// saturation with scale 2^127
00000030 7F000000 00010000 FFFF0000 00000001 00000000
7F7FFFFF FF7FFFFF 78020500 00000000 00000003
00000031 7F000000 00000000 00000000 00000001 7FFFFFFF
00000000 00000000 78020500 7F7FFFFF 00000008
// subnormal range with scale 2^-126
00000040 00800000 00000001 FFFFFFFF 00000100 00002000
00000208 80000208 00020814 00410280 00000000
00000041 00800000 80000000 00000400 00000003 FFFFFFFD
89020500 00082050 00000618 80000618 00000000
// back to back, scale written with the previous vector
00000050 3F800000 00000001 00000002 00000004 00000008
38820500 39020500 39820500 3A020500 00000000
00000051 40000000 00000001 00000002 00000004 00000008
39020500 39820500 3A020500 3A820500 00000000
00000052 3FC00000 00000001 FFFFFFFE 00000003 00000400
38C30780 B9430780 399245A0 3DC30780 00000000
00000053 3F800000 FFFFFFFF 00000000 00000003 00002000
B8820500 00000000 39430780 3F020500 00000000
00000054 00000000 00000005 FFFFFFFB 00000000 00000007
00000000 80000000 00000000 00000000 00000000

// File: vlog.f
hdl/dequant_pkg.sv
hdl/dequant_feed.sv
hdl/dequantize_elem.sv
hdl/dequant_collect.sv
hdl/dequant_top.sv
verification/dequant_asserts.sv
verification/dequant_tb.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= dequant_tb
FILELIST    ?= vlog.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing --assert -Wno-fatal
PASS_STRING ?= ALL CHECKS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_STRING)$$"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/dequant_tb.sv
`timescale 1ns/1ps

module dequant_tb
    import dequant_pkg::*;
();

    localparam int NUM_PAT   = 14;
    localparam int PAT_WORDS = 11;  // id, scale, 4 acc, 4 result, mask
    localparam int MAX_CYC   = NUM_PAT * 8 + 50;

    logic     clk_i;
    logic     rst_i;
    logic     scale_we_i;
    fp32_t    scale_i;
    logic     in_valid_i;
    acc_vec_t acc_vec_i;
    logic     sat_clr_i;
    logic     out_valid_o;
    res_vec_t res_vec_o;
    logic     sat_o;

    logic [31:0] pat_mem [0:NUM_PAT*PAT_WORDS-1];
    int          exp_q[$];
    int          due_q[$];  // cycle in which each pending strobe is due
    int          seed = 32'h047e_9461;
    int          err_count = 0;
    int          test_count = 0;
    int          fail_tests = 0;
    int          cycles = 0;
    logic        exp_sat = 1'b0;
    logic        sat_track = 1'b1;

    dequant_top dequant_top_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .scale_we_i  (scale_we_i),
        .scale_i     (scale_i),
        .in_valid_i  (in_valid_i),
        .acc_vec_i   (acc_vec_i),
        .sat_clr_i   (sat_clr_i),
        .out_valid_o (out_valid_o),
        .res_vec_o   (res_vec_o),
        .sat_o       (sat_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // run limit
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYC) begin
            $display("timeout: outputs still missing after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // outputs change on the rising edge, sampled on the falling one
    always @(negedge clk_i) begin
        int idx;
        int due;
        int base;
        int bad;
        if (!rst_i) begin
            if (sat_track && sat_o !== exp_sat) begin
                $display("Mismatch sat_o: got %h expected %h", sat_o, exp_sat);
                err_count++;
            end
            if (out_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("output strobe seen with no vector pending");
                    err_count++;
                end else begin
                    idx  = exp_q.pop_front();
                    due  = due_q.pop_front();
                    base = idx * PAT_WORDS;
                    bad  = 0;
                    if (cycles != due) begin
                        $display("test %h: output strobe in cycle %0d, expected in cycle %0d",
                                 pat_mem[base][7:0], cycles, due);
                        bad++;
                    end
                    for (int l = 0; l < LANES; l++) begin
                        if (res_vec_o.lane[l] !== pat_mem[base+6+l]) begin
                            $display("Mismatch res_vec_o.lane[%0d]: got %h expected %h",
                                     l, res_vec_o.lane[l], pat_mem[base+6+l]);
                            bad++;
                        end
                    end
                    err_count += bad;
                    test_count++;
                    if (bad != 0) begin
                        fail_tests++;
                    end
                    $display("test %h: %s", pat_mem[base][7:0], (bad == 0) ? "ok" : "bad");
                    if (pat_mem[base+10] != 0) begin
                        exp_sat = 1'b1;  // visible from the next cycle
                    end
                end
            end
        end
    end

    task automatic drive_vector(input int idx, inout fp32_t cur_scale);
        int    base;
        fp32_t next_scale;
        base = idx * PAT_WORDS;
        in_valid_i = 1'b1;
        for (int l = 0; l < LANES; l++) begin
            acc_vec_i.lane[l] = pat_mem[base+2+l];
        end
        // the scale of the next vector is written alongside this one
        next_scale = (idx + 1 < NUM_PAT) ? pat_mem[base+PAT_WORDS+1] : cur_scale;
        if (next_scale != cur_scale) begin
            scale_we_i = 1'b1;
            scale_i    = next_scale;
            cur_scale  = next_scale;
        end else begin
            scale_we_i = 1'b0;
        end
        exp_q.push_back(idx);
        due_q.push_back(cycles + 2);  // captured next edge, registered one edge later
    endtask

    task automatic idle_inputs();
        in_valid_i = 1'b0;
        scale_we_i = 1'b0;
    endtask

    initial begin
        fp32_t cur_scale;
        int    gap;
        $readmemh("verification/dequant_patterns.hex", pat_mem);
        rst_i      = 1'b1;
        scale_we_i = 1'b0;
        scale_i    = '0;
        in_valid_i = 1'b0;
        acc_vec_i  = '0;
        sat_clr_i  = 1'b0;
        cur_scale  = '0;  // scale register after reset
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        for (int i = 0; i < NUM_PAT; i++) begin
            // burst group goes back to back
            if (pat_mem[i*PAT_WORDS][7:4] == 4'h5) begin
                gap = 0;
            end else begin
                gap = $unsigned($random(seed)) % 3;
            end
            repeat (gap) begin
                @(negedge clk_i);
                idle_inputs();
            end
            @(negedge clk_i);
            drive_vector(i, cur_scale);
        end
        @(negedge clk_i);
        idle_inputs();

        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (2) @(negedge clk_i);

        // sticky flag check and clear
        @(posedge clk_i);
        sat_track = 1'b0;
        @(negedge clk_i);
        if (sat_o !== exp_sat) begin
            $display("Mismatch sat_o: got %h expected %h", sat_o, exp_sat);
            err_count++;
        end
        sat_clr_i = 1'b1;
        @(negedge clk_i);
        sat_clr_i = 1'b0;
        if (sat_o !== 1'b0) begin
            $display("Mismatch sat_o: got %h expected %h", sat_o, 1'b0);
            err_count++;
        end

        $display("tests %0d, failed %0d, errors %0d", test_count, fail_tests, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verification/dequant_asserts.sv
`timescale 1ns/1ps

module dequant_asserts
    import dequant_pkg::*;
(
    input logic             clk_i,
    input logic             rst_i,
    input logic             valid_i,
    input logic             out_valid_o,
    input logic             sat_o,
    input logic [LANES-1:0] ovf_q
);

    // output strobe is the lane strobe delayed by one register
    valid_to_out: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |=> out_valid_o)
        else $error("out_valid_o did not follow valid_i");

    no_spurious_out: assert property (@(posedge clk_i) disable iff (rst_i)
        !valid_i |=> !out_valid_o)
        else $error("out_valid_o high without valid_i one cycle before");

    reset_clears: assert property (@(posedge clk_i)
        rst_i |=> (!out_valid_o && !sat_o))
        else $error("out_valid_o or sat_o high after reset");

    // sticky flag only rises behind an overflowing strobe
    sat_cause: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(sat_o) |-> $past(out_valid_o && (|ovf_q)))
        else $error("sat_o rose without an overflowing output strobe");

endmodule

bind dequant_collect dequant_asserts dequant_asserts_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .out_valid_o (out_valid_o),
    .sat_o       (sat_o),
    .ovf_q       (ovf_q)
);

// File: hdl/dequant_top.sv
`timescale 1ns/1ps

module dequant_top
    import dequant_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     scale_we_i,
    input  fp32_t    scale_i,
    input  logic     in_valid_i,
    input  acc_vec_t acc_vec_i,
    input  logic     sat_clr_i,
    output logic     out_valid_o,
    output res_vec_t res_vec_o,
    output logic     sat_o
);

    scale_t           lane_scale;
    acc_vec_t         lane_acc;
    logic             lane_valid;
    res_vec_t         lane_res;
    logic [LANES-1:0] lane_ovf;

    dequant_feed dequant_feed_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .scale_we_i (scale_we_i),
        .scale_i    (scale_i),
        .in_valid_i (in_valid_i),
        .acc_vec_i  (acc_vec_i),
        .scale_o    (lane_scale),
        .acc_vec_o  (lane_acc),
        .valid_o    (lane_valid)
    );

    // combinational lanes, all share one scale
    for (genvar g = 0; g < LANES; g++) begin : gen_lane
        dequantize_elem dequantize_elem_inst (
            .acc_i    (lane_acc.lane[g]),
            .scale_i  (lane_scale),
            .r_data_o (lane_res.lane[g]),
            .ovf_o    (lane_ovf[g])
        );
    end

    dequant_collect dequant_collect_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (lane_valid),
        .res_i       (lane_res),
        .ovf_i       (lane_ovf),
        .sat_clr_i   (sat_clr_i),
        .out_valid_o (out_valid_o),
        .res_vec_o   (res_vec_o),
        .sat_o       (sat_o)
    );

endmodule

// File: hdl/dequant_collect.sv
`timescale 1ns/1ps

module dequant_collect
    import dequant_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             valid_i,
    input  res_vec_t         res_i,
    input  logic [LANES-1:0] ovf_i,
    input  logic             sat_clr_i,
    output logic             out_valid_o,
    output res_vec_t         res_vec_o,
    output logic             sat_o
);

    res_vec_t         res_q;
    logic [LANES-1:0] ovf_q;  // overflow lanes of the last strobed vector
    logic             valid_q;
    logic             sat_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // held between strobes
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            res_q <= res_i;
            ovf_q <= ovf_i;
        end
    end

    // sticky, set one cycle after an overflowing strobe, set wins over clear
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sat_q <= 1'b0;
        end else if (valid_q && (|ovf_q)) begin
            sat_q <= 1'b1;
        end else if (sat_clr_i) begin
            sat_q <= 1'b0;
        end
    end

    assign out_valid_o = valid_q;
    assign res_vec_o   = res_q;
    assign sat_o       = sat_q;

endmodule

// File: hdl/dequantize_elem.sv
`timescale 1ns/1ps

module dequantize_elem
    import dequant_pkg::*;
(
    input  acc_t   acc_i,
    input  scale_t scale_i,
    output fp32_t  r_data_o,
    output logic   ovf_o
);

    logic                         sign_acc;
    logic [FP_DATA_W-1:0]         acc_mag;
    logic                         acc_zero;
    logic                         scale_zero;
    logic                         is_zero;
    logic [MANT_W-1:0]            scale_mant;
    logic [PROD_W-1:0]            prod;
    logic [IDX_W-1:0]             msb_idx;
    logic [IDX_W-1:0]             rsh;
    logic [PROD_W-1:0]            prod_shr;
    logic [PROD_W-1:0]            prod_g;
    logic [PROD_W-1:0]            low_mask;
    logic                         guard;
    logic                         sticky;
    logic                         round_up;
    logic [MANT_W:0]              mant_rnd;
    logic                         rnd_carry;
    logic [MANT_W-1:0]            mant_norm;
    logic [MANT_W:0]              adj_sum;
    logic                         adj_carry;
    logic [MANT_W-1:0]            mant_fixed;
    logic signed [EXP_CALC_W-1:0] new_unb;
    logic signed [EXP_CALC_W-1:0] exp_biased;
    logic signed [EXP_CALC_W-1:0] sub_shift;
    logic                         oflow;
    logic                         uflow;
    logic [MANT_W:0]              sub_rnd;
    logic [MANT_W-1:0]            mant_sub;
    logic [FP_EXP_W-1:0]          exp_out;
    logic [FP_MANT_W-1:0]         frac_out;

    assign sign_acc   = acc_i[FP_DATA_W-1];
    assign acc_mag    = sign_acc ? (~acc_i + 1'b1) : acc_i;  // -2^31 maps to 2^31
    assign acc_zero   = (acc_i == '0);
    assign scale_zero = (scale_i.exponent == '0) && (scale_i.mantissa == '0);
    assign is_zero    = acc_zero | scale_zero;

    assign scale_mant = {1'b1, scale_i.mantissa};
    assign prod       = acc_mag * scale_mant;

    // leading one, highest set bit wins
    always_comb begin
        msb_idx = '0;
        for (int k = 0; k < PROD_W; k++) begin
            if (prod[k]) begin
                msb_idx = IDX_W'(k);
            end
        end
    end

    // |acc| >= 1 puts the leading one at MANT_W-1 or above, so only a right shift
    assign rsh = (msb_idx >= IDX_W'(MANT_W - 1)) ? msb_idx - IDX_W'(MANT_W - 1) : '0;
    assign prod_shr = prod >> rsh;

    always_comb begin
        if (rsh != '0) begin
            prod_g   = prod >> (rsh - 1'b1);
            guard    = prod_g[0];
            low_mask = (PROD_W'(1) << (rsh - 1'b1)) - 1'b1;
        end else begin
            prod_g   = prod;
            guard    = 1'b0;
            low_mask = '0;
        end
        sticky = |(prod & low_mask);
    end

    // ties to even
    assign round_up  = guard & (sticky | prod_shr[0]);
    assign mant_rnd  = {1'b0, prod_shr[MANT_W-1:0]} + (MANT_W + 1)'(round_up);
    assign rnd_carry = mant_rnd[MANT_W];
    assign mant_norm = rnd_carry ? mant_rnd[MANT_W:1] : mant_rnd[MANT_W-1:0];

    // 2^14 / 127^2 ~ 1 + 1/64 + 1/8192 + 1/32768, truncated
    assign adj_sum    = {1'b0, mant_norm} + (mant_norm >> 6) + (mant_norm >> 13)
                      + (mant_norm >> 15);
    assign adj_carry  = adj_sum[MANT_W];
    assign mant_fixed = adj_carry ? adj_sum[MANT_W:1] : adj_sum[MANT_W-1:0];

    // unbiased result exponent, /Q^2 handled as -Q2_SHIFT
    assign new_unb = $signed(EXP_CALC_W'(msb_idx) + EXP_CALC_W'(scale_i.exponent)
                   + EXP_CALC_W'(rnd_carry) + EXP_CALC_W'(adj_carry)
                   - EXP_CALC_W'(FP_EXP_BIAS + FP_MANT_W + Q2_SHIFT));

    assign exp_biased = new_unb + EXP_CALC_W'(FP_EXP_BIAS);
    assign oflow      = (new_unb > UNB_MAX);
    assign uflow      = (new_unb < UNB_MIN);
    assign sub_shift  = EXP_CALC_W'(UNB_MIN) - new_unb;  // > 0 when subnormal

    // subnormal denormalize, round half up
    always_comb begin
        sub_rnd  = '0;
        mant_sub = mant_fixed;
        if (sub_shift >= MANT_W) begin
            mant_sub = '0;
        end else if (sub_shift > 0) begin
            sub_rnd  = (MANT_W + 1)'(mant_fixed) + ((MANT_W + 1)'(1) << (sub_shift - 1));
            mant_sub = MANT_W'(sub_rnd >> sub_shift);
        end
    end

    always_comb begin
        if (is_zero) begin
            exp_out  = '0;
            frac_out = '0;
        end else if (oflow) begin
            exp_out  = {{(FP_EXP_W - 1){1'b1}}, 1'b0};  // max finite
            frac_out = '1;
        end else if (uflow) begin
            // rounding up into the hidden bit yields the smallest normal
            exp_out  = FP_EXP_W'(mant_sub[MANT_W-1]);
            frac_out = mant_sub[FP_MANT_W-1:0];
        end else begin
            exp_out  = exp_biased[FP_EXP_W-1:0];
            frac_out = mant_fixed[FP_MANT_W-1:0];
        end
    end

    assign ovf_o    = oflow & ~is_zero;
    assign r_data_o = {sign_acc, exp_out, frac_out};  // zero result keeps the acc sign

endmodule

// File: hdl/dequant_feed.sv
`timescale 1ns/1ps

module dequant_feed
    import dequant_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     scale_we_i,
    input  fp32_t    scale_i,
    input  logic     in_valid_i,
    input  acc_vec_t acc_vec_i,
    output scale_t   scale_o,
    output acc_vec_t acc_vec_o,
    output logic     valid_o
);

    scale_t   scale_q;      // programmed scale
    scale_t   scale_cap_q;  // scale snapshot taken with the vector
    acc_vec_t acc_cap_q;
    logic     valid_q;

    // sign bit of the written word is dropped, scale taken as magnitude
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            scale_q <= '0;
        end else if (scale_we_i) begin
            scale_q.exponent <= scale_i[FP_DATA_W-2 -: FP_EXP_W];
            scale_q.mantissa <= scale_i[FP_MANT_W-1:0];
        end
    end

    // a scale written on the same edge only reaches later vectors
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            acc_cap_q   <= acc_vec_i;
            scale_cap_q <= scale_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid_i;
        end
    end

    assign scale_o   = scale_cap_q;
    assign acc_vec_o = acc_cap_q;
    assign valid_o   = valid_q;

endmodule

// File: hdl/dequant_pkg.sv
package dequant_pkg;

    // IEEE-754 single precision
    localparam int FP_DATA_W   = 32;
    localparam int FP_MANT_W   = 23;
    localparam int FP_EXP_W    = 8;
    localparam int FP_EXP_BIAS = 127;

    localparam int BIT_NUM = 8;    // int8 operands
    localparam int LANES   = 4;

    localparam int MANT_W     = FP_MANT_W + 1;             // 1.m
    localparam int QMAX       = (1 << (BIT_NUM - 1)) - 1;  // 127
    localparam int Q2_SHIFT   = $clog2(QMAX * QMAX);       // 14, /Q^2 as exponent shift
    localparam int PROD_W     = FP_DATA_W + MANT_W;        // |acc| * 1.m
    localparam int IDX_W      = $clog2(PROD_W);
    localparam int UNB_MIN    = 1 - FP_EXP_BIAS;                        // -126
    localparam int UNB_MAX    = (1 << FP_EXP_W) - 2 - FP_EXP_BIAS;      // +127
    localparam int EXP_CALC_W = FP_EXP_W + 6;              // signed exponent scratch

    typedef logic signed [FP_DATA_W-1:0] acc_t;
    typedef logic        [FP_DATA_W-1:0] fp32_t;

    typedef struct packed {
        logic [FP_EXP_W-1:0]  exponent;  // biased
        logic [FP_MANT_W-1:0] mantissa;  // hidden bit not stored
    } scale_t;

    typedef struct packed {
        acc_t [LANES-1:0] lane;
    } acc_vec_t;

    typedef struct packed {
        fp32_t [LANES-1:0] lane;
    } res_vec_t;

endpackage
